//--- ecc_params.svh
// Hamming codec widths
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Data bits per word
`define ECC_DATA_W 4

// Data plus three parity bits
`define ECC_CODE_W 7

// One bit per parity check
`define ECC_SYN_W 3

// Width of the error counters
`define ECC_COUNT_W 8

`endif

//--- ecc_code_pkg.sv
// Hamming(7,4) code types
`include "ecc_params.svh"

package ecc_code_pkg;

    typedef logic [`ECC_DATA_W-1:0] data_word_t;  // {d4, d3, d2, d1}

    // Bit order p1 p2 d1 p3 d2 d3 d4 from bit 0 upward
    typedef logic [`ECC_CODE_W-1:0] codeword_t;

    typedef logic [`ECC_SYN_W-1:0] syndrome_t;  // 1-based position of the bad bit

    typedef enum logic [1:0] {
        ERR_NONE,    // Syndrome zero
        ERR_DATA,    // Syndrome 3, 5, 6 or 7
        ERR_PARITY   // Syndrome 1, 2 or 4
    } err_class_t;

    // Parity checks over a codeword
    // With the parity bits zeroed this gives the parity bits to store
    function automatic syndrome_t calc_syndrome(codeword_t cw);
        syndrome_t syn;
        syn[0] = cw[0] ^ cw[2] ^ cw[4] ^ cw[6];
        syn[1] = cw[1] ^ cw[2] ^ cw[5] ^ cw[6];
        syn[2] = cw[3] ^ cw[4] ^ cw[5] ^ cw[6];
        return syn;
    endfunction

endpackage

//--- ecc_log_pkg.sv
// Error log types
`include "ecc_params.svh"

package ecc_log_pkg;

    // Unsigned event counter
    typedef logic [`ECC_COUNT_W-1:0] err_count_t;

    // Counters stop here
    localparam err_count_t COUNT_MAX = '1;

endpackage

//--- ecc_result_if.sv
// Decode result channel
interface ecc_result_if;
    import ecc_code_pkg::*;

    data_word_t data;       // Corrected data bits
    err_class_t err_class;  // What the syndrome pointed at
    logic       valid;
    logic       ready;

    // Decoder side
    modport source (
        output data,
        output err_class,
        output valid,
        input  ready
    );

    // Observers, never drive ready
    modport monitor (
        input data,
        input err_class,
        input valid,
        input ready
    );

endinterface

//--- hamming_encoder.sv
// Hamming(7,4) encoder
module hamming_encoder (
    input  logic                     clock,
    input  logic                     reset,
    input  ecc_code_pkg::data_word_t data,
    input  logic                     valid,
    output logic                     ready,
    output ecc_code_pkg::codeword_t  codeword,
    output logic                     cw_valid,
    input  logic                     cw_ready
);
    import ecc_code_pkg::*;

    codeword_t spread;    // Data in place, parity bits zero
    syndrome_t parity;
    codeword_t next_cw;

    // Data bits go to positions 3, 5, 6 and 7
    assign spread = {data[3], data[2], data[1], 1'b0, data[0], 2'b00};

    // Same checks the decoder runs, so a clean word gives syndrome zero
    assign parity = calc_syndrome(spread);

    assign next_cw = {spread[6:4], parity[2], spread[2], parity[1], parity[0]};

    // Output slot empty or draining this cycle
    assign ready = !cw_valid || cw_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            cw_valid <= 1'b0;
        end else if (ready) begin
            cw_valid <= valid;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge clock) begin
        if (ready && valid) begin
            codeword <= next_cw;
        end
    end

endmodule

//--- hamming_decoder.sv
// Hamming(7,4) decoder pipeline
`include "ecc_params.svh"

module hamming_decoder (
    input  logic                    clock,
    input  logic                    reset,
    input  ecc_code_pkg::codeword_t codeword,
    input  logic                    valid,
    output logic                    ready,
    ecc_result_if.source            result
);
    import ecc_code_pkg::*;

    logic advance;  // Whole pipe moves as one

    // Stage 1
    codeword_t s1_cw;
    logic      s1_valid;
    syndrome_t s1_syn;

    // Stage 2
    codeword_t  s2_cw;
    syndrome_t  s2_syn;
    logic       s2_valid;
    codeword_t  s2_flip;       // One-hot bit to invert
    err_class_t s2_class;
    codeword_t  s2_corrected;

    // Free output slot or a result leaving now
    assign advance = !result.valid || result.ready;
    assign ready   = advance;

    // Stage 1 registers and syndrome
    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s1_cw <= codeword;
        end
    end

    assign s1_syn = calc_syndrome(s1_cw);

    // Stage 2 registers
    always_ff @(posedge clock) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s2_cw  <= s1_cw;
            s2_syn <= s1_syn;
        end
    end

    // Syndrome names the bit position, zero means clean
    always_comb begin
        s2_flip = '0;
        for (int i = 0; i < `ECC_CODE_W; i++) begin
            if (s2_syn == syndrome_t'(i + 1)) begin
                s2_flip[i] = 1'b1;
            end
        end
    end

    // Powers of two sit on parity bits
    always_comb begin
        case (s2_syn)
            3'd0:             s2_class = ERR_NONE;
            3'd1, 3'd2, 3'd4: s2_class = ERR_PARITY;
            default:          s2_class = ERR_DATA;
        endcase
    end

    // Double errors land here too and get miscorrected
    assign s2_corrected = s2_cw ^ s2_flip;

    // Stage 3 output registers
    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (advance) begin
            result.valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            result.data      <= {s2_corrected[6:4], s2_corrected[2]};
            result.err_class <= s2_class;
        end
    end

endmodule

//--- ecc_error_log.sv
// Decode error counters
module ecc_error_log (
    input  logic                    clock,
    input  logic                    reset,
    ecc_result_if.monitor           result,
    output ecc_log_pkg::err_count_t data_errors,
    output ecc_log_pkg::err_count_t parity_errors
);
    import ecc_code_pkg::*;
    import ecc_log_pkg::*;

    logic take;       // A result leaves the decoder
    logic data_sat;
    logic parity_sat;

    assign take       = result.valid && result.ready;
    assign data_sat   = (data_errors == COUNT_MAX);
    assign parity_sat = (parity_errors == COUNT_MAX);

    // Counts show one cycle after the transfer
    always_ff @(posedge clock) begin
        if (reset) begin
            data_errors   <= '0;
            parity_errors <= '0;
        end else if (take) begin
            case (result.err_class)
                ERR_DATA: begin
                    if (!data_sat) begin
                        data_errors <= data_errors + 1'b1;
                    end
                end
                ERR_PARITY: begin
                    if (!parity_sat) begin
                        parity_errors <= parity_errors + 1'b1;
                    end
                end
                default: begin
                    // Clean word, nothing to log
                end
            endcase
        end
    end

endmodule

//--- ecc_codec.sv
// Hamming codec top level
module ecc_codec (
    input  logic                     clock,
    input  logic                     reset,
    // Encode path
    input  ecc_code_pkg::data_word_t enc_data,
    input  logic                     enc_valid,
    output logic                     enc_ready,
    output ecc_code_pkg::codeword_t  enc_codeword,
    output logic                     enc_cw_valid,
    input  logic                     enc_cw_ready,
    // Decode path
    input  ecc_code_pkg::codeword_t  dec_codeword,
    input  logic                     dec_valid,
    output logic                     dec_ready,
    output ecc_code_pkg::data_word_t dec_data,
    output ecc_code_pkg::err_class_t dec_error,
    output logic                     dec_out_valid,
    input  logic                     dec_out_ready,
    // Error log
    output ecc_log_pkg::err_count_t  data_errors,
    output ecc_log_pkg::err_count_t  parity_errors
);

    ecc_result_if result_bus ();

    hamming_encoder u_encoder (
        .clock    (clock),
        .reset    (reset),
        .data     (enc_data),
        .valid    (enc_valid),
        .ready    (enc_ready),
        .codeword (enc_codeword),
        .cw_valid (enc_cw_valid),
        .cw_ready (enc_cw_ready)
    );

    hamming_decoder u_decoder (
        .clock    (clock),
        .reset    (reset),
        .codeword (dec_codeword),
        .valid    (dec_valid),
        .ready    (dec_ready),
        .result   (result_bus.source)
    );

    ecc_error_log u_error_log (
        .clock         (clock),
        .reset         (reset),
        .result        (result_bus.monitor),
        .data_errors   (data_errors),
        .parity_errors (parity_errors)
    );

    // Result channel out to the pins
    assign result_bus.ready = dec_out_ready;
    assign dec_data         = result_bus.data;
    assign dec_error        = result_bus.err_class;
    assign dec_out_valid    = result_bus.valid;

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 ns period
    end

    // Held over the first 8 rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- ecc_codec_props.sv
// Codec handshake assertions
module ecc_codec_props (
    input logic                     clock,
    input logic                     reset,
    input ecc_code_pkg::codeword_t  enc_codeword,
    input logic                     enc_cw_valid,
    input logic                     enc_cw_ready,
    input ecc_code_pkg::data_word_t dec_data,
    input ecc_code_pkg::err_class_t dec_error,
    input logic                     dec_out_valid,
    input logic                     dec_out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled encode word stays put
    enc_hold: assert property (@(posedge clock) disable iff (reset)
        enc_cw_valid && !enc_cw_ready |=> enc_cw_valid && $stable(enc_codeword))
        else $error("enc_cw_valid dropped or enc_codeword changed before enc_cw_ready");

    dec_hold: assert property (@(posedge clock) disable iff (reset)
        dec_out_valid && !dec_out_ready |=>
            dec_out_valid && $stable(dec_data) && $stable(dec_error))
        else $error("dec_out_valid dropped or its result changed before dec_out_ready");

    // Outputs quiet through reset and the cycle after it
    enc_reset_low: assert property (@(posedge clock) reset |=> !enc_cw_valid)
        else $error("enc_cw_valid high during or right after reset");

    dec_reset_low: assert property (@(posedge clock) reset |=> !dec_out_valid)
        else $error("dec_out_valid high during or right after reset");

endmodule

//--- ecc_codec_tb.sv
// Hamming codec testbench
module ecc_codec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ecc_code_pkg::*;
    import ecc_log_pkg::*;

    logic       clock;
    logic       reset;
    data_word_t enc_data;
    logic       enc_valid;
    logic       enc_ready;
    codeword_t  enc_codeword;
    logic       enc_cw_valid;
    logic       enc_cw_ready;
    codeword_t  dec_codeword;
    logic       dec_valid;
    logic       dec_ready;
    data_word_t dec_data;
    err_class_t dec_error;
    logic       dec_out_valid;
    logic       dec_out_ready;
    err_count_t data_errors;
    err_count_t parity_errors;

    // Vectors from the stim file
    data_word_t stim_data[$];
    codeword_t  stim_mask[$];
    codeword_t  stim_cw[$];
    data_word_t stim_exp[$];
    err_class_t stim_class[$];
    err_count_t exp_data_errors;
    err_count_t exp_parity_errors;

    // Scoreboards with the oldest entry first
    codeword_t  enc_expect[$];
    data_word_t dec_expect_data[$];
    err_class_t dec_expect_class[$];

    logic [15:0] lfsr_state;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    ecc_codec UUT (.*);

    bind ecc_codec ecc_codec_props props (
        .clock         (clock),
        .reset         (reset),
        .enc_codeword  (enc_codeword),
        .enc_cw_valid  (enc_cw_valid),
        .enc_cw_ready  (enc_cw_ready),
        .dec_data      (dec_data),
        .dec_error     (dec_error),
        .dec_out_valid (dec_out_valid),
        .dec_out_ready (dec_out_ready)
    );

    task automatic report_failure(input string what);
        if (what.len() > 0) begin
            $display("%s", what);
        end
        $display("Errors found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_codeword(input string name, input codeword_t expected,
                                  input codeword_t actual);
        if (actual !== expected) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            report_failure("");
        end
    endtask

    task automatic check_data(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            report_failure("");
        end
    endtask

    task automatic check_class(input string name, input err_class_t expected,
                               input err_class_t actual);
        if (actual !== expected) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            report_failure("");
        end
    endtask

    task automatic check_count(input string name, input err_count_t expected,
                               input err_count_t actual);
        if (actual !== expected) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            report_failure("");
        end
    endtask

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_random_bit(output logic value);
        lfsr_state = lfsr_step(lfsr_state);
        value = lfsr_state[0];
    endtask

    task automatic load_stim();
        int         fd;
        int         got;
        string      line;
        logic [7:0] f_data;
        logic [7:0] f_mask;
        logic [7:0] f_cw;
        logic [7:0] f_exp;
        logic [7:0] f_cls;
        fd = $fopen("ecc_stim.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open ecc_stim.txt");
        end
        exp_data_errors = '0;
        exp_parity_errors = '0;
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                got = $sscanf(line, "%h %h %h %h %h", f_data, f_mask, f_cw, f_exp, f_cls);
                if (got == 5) begin
                    stim_data.push_back(f_data[3:0]);
                    stim_mask.push_back(f_mask[6:0]);
                    stim_cw.push_back(f_cw[6:0]);
                    stim_exp.push_back(f_exp[3:0]);
                    stim_class.push_back(err_class_t'(f_cls[1:0]));
                    if (f_cls[1:0] == 2'd1) exp_data_errors = exp_data_errors + 1'b1;
                    if (f_cls[1:0] == 2'd2) exp_parity_errors = exp_parity_errors + 1'b1;
                end
            end
        end
        $fclose(fd);
        if (stim_data.size() == 0) begin
            report_failure("The stim file held no vectors");
        end
    endtask

    // One word through each path with both readies high
    task automatic run_latency(input int idx);
        int cycles;
        @(negedge clock);
        enc_cw_ready = 1'b1;
        dec_out_ready = 1'b1;
        enc_data = stim_data[idx];
        enc_valid = 1'b1;
        dec_codeword = stim_cw[idx] ^ stim_mask[idx];
        dec_valid = 1'b1;
        #1;
        if (!enc_ready || !dec_ready) begin
            report_failure("An input ready was low while both paths were idle");
        end
        cycles = 0;
        while (!dec_out_valid) begin
            @(negedge clock);
            enc_valid = 1'b0;
            dec_valid = 1'b0;
            cycles++;
            if (cycles == 1) begin
                if (!enc_cw_valid) begin
                    report_failure("enc_cw_valid was not set one cycle after the transfer");
                end
                check_codeword("enc_codeword", stim_cw[idx], enc_codeword);
            end
            if (cycles > 10) begin
                report_failure("dec_out_valid never went high in the latency run");
            end
        end
        if (cycles != 3) begin
            report_failure("A decode result did not arrive 3 cycles after its transfer");
        end
        check_data("dec_data", stim_exp[idx], dec_data);
        check_class("dec_error", stim_class[idx], dec_error);
    endtask

    // All vectors through both paths under random back-pressure
    task automatic run_stream();
        int   enc_idx;
        int   dec_idx;
        int   cycles;
        int   total;
        logic bit_val;
        enc_idx = 0;
        dec_idx = 0;
        cycles = 0;
        total = stim_data.size();
        while (enc_idx < total || dec_idx < total ||
               enc_expect.size() > 0 || dec_expect_data.size() > 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > 2000) begin
                if (dec_idx < total || dec_expect_data.size() > 0) begin
                    report_failure("dec_out_valid never delivered every result in time");
                end else begin
                    report_failure("enc_cw_valid never delivered every codeword in time");
                end
            end
            enc_valid = (enc_idx < total);
            if (enc_idx < total) enc_data = stim_data[enc_idx];
            dec_valid = (dec_idx < total);
            if (dec_idx < total) dec_codeword = stim_cw[dec_idx] ^ stim_mask[dec_idx];
            take_random_bit(bit_val);
            enc_cw_ready = bit_val;
            take_random_bit(bit_val);
            dec_out_ready = bit_val;
            #1;  // Let the ready outputs settle

            // Outputs leaving at the coming rising edge
            if (enc_cw_valid && enc_cw_ready) begin
                if (enc_expect.size() == 0) begin
                    report_failure("enc_cw_valid was high with no word outstanding");
                end
                check_codeword("enc_codeword", enc_expect.pop_front(), enc_codeword);
            end
            if (dec_out_valid && dec_out_ready) begin
                if (dec_expect_data.size() == 0) begin
                    report_failure("dec_out_valid was high with no codeword outstanding");
                end
                check_data("dec_data", dec_expect_data.pop_front(), dec_data);
                check_class("dec_error", dec_expect_class.pop_front(), dec_error);
            end

            // Inputs taken at the same edge
            if (enc_valid && enc_ready) begin
                enc_expect.push_back(stim_cw[enc_idx]);
                enc_idx++;
            end
            if (dec_valid && dec_ready) begin
                dec_expect_data.push_back(stim_exp[dec_idx]);
                dec_expect_class.push_back(stim_class[dec_idx]);
                dec_idx++;
            end
        end
    endtask

    initial begin
        int waited;
        enc_data = '0;
        enc_valid = 1'b1;  // Words offered at the first reset edge must not get through
        enc_cw_ready = 1'b1;
        dec_codeword = '0;
        dec_valid = 1'b1;
        dec_out_ready = 1'b1;
        lfsr_state = 16'd21;
        load_stim();

        @(posedge clock);
        @(negedge clock);
        enc_valid = 1'b0;
        dec_valid = 1'b0;

        waited = 0;
        while (reset !== 1'b0) begin
            @(negedge clock);
            waited++;
            if (waited > 20) begin
                report_failure("reset was never released");
            end
        end

        for (int i = 0; i < stim_data.size(); i++) begin
            if (stim_mask[i] == '0) run_latency(i);  // Clean words leave the counters alone
        end
        run_stream();

        // Counters show one cycle after the last transfer
        @(negedge clock);
        enc_valid = 1'b0;
        dec_valid = 1'b0;
        if (enc_cw_valid || dec_out_valid) begin
            report_failure("An output was still valid after every word had been delivered");
        end
        check_count("data_errors", exp_data_errors, data_errors);
        check_count("parity_errors", exp_parity_errors, parity_errors);
        $display("No errors");
        $finish;
    end

endmodule

//--- ecc_stim.txt
// data mask codeword decoded class, all hex
// class 0 clean, 1 data bit flipped, 2 parity bit flipped
0 00 00 0 0
1 00 07 1 0
2 00 19 2 0
3 00 1e 3 0
4 00 2a 4 0
5 00 2d 5 0
6 00 33 6 0
7 00 34 7 0
8 00 4b 8 0
9 00 4c 9 0
a 00 52 a 0
b 00 55 b 0
c 00 61 c 0
d 00 66 d 0
e 00 78 e 0
f 00 7f f 0
3 01 1e 3 2
5 02 2d 5 2
9 04 4c 9 1
c 08 61 c 2
6 10 33 6 1
a 20 52 a 1
f 40 7f f 1
0 40 00 0 1
1 01 07 1 2
2 08 19 2 2
4 10 2a 4 1
7 02 34 7 2
8 20 4b 8 1
b 04 55 b 1
d 40 66 d 1
e 08 78 e 2
6 01 33 6 2
9 10 4c 9 1

//--- build.f
+incdir+.
ecc_code_pkg.sv
ecc_log_pkg.sv
ecc_result_if.sv
hamming_encoder.sv
hamming_decoder.sv
ecc_error_log.sv
ecc_codec.sv
tb_clock_gen.sv
ecc_codec_props.sv
ecc_codec_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= ecc_codec_tb
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --assert --timescale 1ns/1ps
OBJ_DIR    ?= obj_dir

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): build.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f build.f

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f build.f

clean:
	rm -rf $(OBJ_DIR)
